// ==== exec_unit_top.f ====
+incdir+include
design/rv_isa_pkg.sv
design/rv_exec_pkg.sv
design/exec_alu.sv
design/exec_mem.sv
design/exec_commit.sv
design/exec_unit_top.sv
dv/exec_unit_checker.sv
dv/exec_unit_assertions.sv
dv/exec_unit_tb.sv

// ==== Bender.yml ====
package:
  name: exec_unit

sources:
  - include_dirs:
      - include
    files:
      - design/rv_isa_pkg.sv
      - design/rv_exec_pkg.sv
      - design/exec_alu.sv
      - design/exec_mem.sv
      - design/exec_commit.sv
      - design/exec_unit_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/exec_unit_checker.sv
      - dv/exec_unit_assertions.sv
      - dv/exec_unit_tb.sv

// ==== dv/exec_unit_tb.sv ====
`timescale 1ns/1ps
`include "rv_exec_settings.svh"

module exec_unit_tb
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;
();

    localparam int N_TESTS      = 26;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = N_TESTS * 20 + RESET_CYCLES;

    typedef struct packed {
        opcode_t op;
        logic    is_mem;
        funct3_t f3;
        funct7_t f7;
        xword_t  a;
        xword_t  b;
        imm12_t  imm;
        logic    exc;
        xword_t  res;
    } test_t;

    logic       clk;
    logic       rst;
    issue_t     issue;
    lsu_rsp_t   lsu_rsp;
    lsu_req_t   lsu_req;
    commit_t    commit;
    logic [7:0] exc_count;

    test_t      tests[N_TESTS];
    string      names[N_TESTS];
    string      cur_name;
    int         n_added;
    int         cycles;
    int         n_exc;
    int         fails;
    integer     seed;
    xword_t     mem[64];

    // LSU model state
    logic       pend;
    int         wait_cnt;
    lsu_req_t   req_q;
    commit_t    exp;

    exec_unit_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .lsu_rsp   (lsu_rsp),
        .lsu_req   (lsu_req),
        .commit    (commit),
        .exc_count (exc_count)
    );

    exec_unit_checker i_chk (
        .clk       (clk),
        .rst       (rst),
        .commit    (commit),
        .exc_count (exc_count)
    );

    task automatic add_test(input string name, input opcode_t op, input logic m,
                            input funct3_t f3, input funct7_t f7, input xword_t a,
                            input xword_t b, input imm12_t imm, input logic exc,
                            input xword_t res);
        names[n_added] = name;
        tests[n_added] = '{op, m, f3, f7, a, b, imm, exc, res};
        n_added++;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: no commit for test %s within %0d cycles", cur_name, CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // --------------------
    // LSU model
    // --------------------
    always @(posedge clk) begin
        if (!rst && !lsu_req.prev_stalled) begin
            pend     <= 1'b1;
            req_q    <= lsu_req;
            wait_cnt <= $unsigned($random(seed)) % 3;
        end
    end

    // answer with stall_next low for one cycle
    always @(negedge clk) begin
        lsu_rsp.stall_next   = 1'b1;
        lsu_rsp.access_fault = 1'b0;
        if (pend && wait_cnt > 0) begin
            wait_cnt = wait_cnt - 1;
        end else if (pend) begin
            pend = 1'b0;
            lsu_rsp.stall_next = 1'b0;
            if (req_q.addr > 63) begin
                lsu_rsp.access_fault = 1'b1;
                lsu_rsp.load_data    = '0;
            end else begin
                for (int b = 0; b < `MASK_W; b++) begin
                    if (req_q.do_store && req_q.store_mask[b])
                        mem[req_q.addr][8*b +: 8] = req_q.store_data[8*b +: 8];
                end
                lsu_rsp.load_data = mem[req_q.addr];
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin
        seed     = 32'h2baf72d2;
        issue    = '0;
        lsu_rsp  = '0;
        lsu_rsp.stall_next = 1'b1;
        rst      = 1'b1;
        pend     = 1'b0;
        wait_cnt = 0;
        cycles   = 0;
        n_added  = 0;
        n_exc    = 0;
        cur_name = "reset";
        for (int i = 0; i < 64; i++)
            mem[i] = (64'(i) * 64'h0101010101010101) ^ 64'h8040201008040201;

        add_test("add", OP_OP, 0, 0, 0, 5, 7, 0, 0, 64'd12);
        add_test("sub", OP_OP, 0, 0, 7'h20, 5, 7, 0, 0, 64'hFFFFFFFFFFFFFFFE);
        add_test("slt", OP_OP, 0, 2, 0, '1, 1, 0, 0, 64'd1);
        add_test("sltu", OP_OP, 0, 3, 0, '1, 1, 0, 0, 64'd0);
        add_test("srai", OP_OP_IMM, 0, 5, 7'h20, 64'h8000000000000000, 0, 12'h404, 0,
                 64'hF800000000000000);
        add_test("xori", OP_OP_IMM, 0, 4, 0, 64'h0123456789ABCDEF, 0, 12'hFFF, 0,
                 64'hFEDCBA9876543210);
        add_test("lb", OP_LOAD, 1, 0, 0, 15, 0, 0, 0, 64'hFFFFFFFFFFFFFF81);
        add_test("lh", OP_LOAD, 1, 1, 0, 22, 0, 0, 0, 64'hFFFFFFFFFFFF8242);
        add_test("lw_neg_imm", OP_LOAD, 1, 2, 0, 20, 0, 12'hFF8, 0, 64'hFFFFFFFF81412111);
        add_test("lwu", OP_LOAD, 1, 6, 0, 28, 0, 0, 0, 64'h0000000083432313);
        add_test("lbu", OP_LOAD, 1, 4, 0, 79, 0, 0, 0, 64'h0000000000000089);
        add_test("lhu", OP_LOAD, 1, 5, 0, 86, 0, 0, 0, 64'h0000000000008A4A);
        add_test("ld", OP_LOAD, 1, 3, 0, 24, 0, 0, 0, 64'h834323130B070102);
        add_test("sb", OP_STORE, 1, 0, 0, 43, 64'hA5, 0, 0, 0);
        add_test("ld_after_sb", OP_LOAD, 1, 3, 0, 40, 0, 0, 0, 64'h85452515A5010704);
        add_test("sw", OP_STORE, 1, 2, 0, 60, 64'h89ABCDEF, 0, 0, 0);
        add_test("lw_after_sw", OP_LOAD, 1, 2, 0, 60, 0, 0, 0, 64'hFFFFFFFF89ABCDEF);
        add_test("sh", OP_STORE, 1, 1, 0, 50, 64'h1234BEEF, 0, 0, 0);
        add_test("ld_after_sh", OP_LOAD, 1, 3, 0, 48, 0, 0, 0, 64'h86462616BEEF0407);
        add_test("sd", OP_STORE, 1, 3, 0, 64, 64'h0F1E2D3C4B5A6978, 0, 0, 0);
        add_test("ld_after_sd", OP_LOAD, 1, 3, 0, 64, 0, 0, 0, 64'h0F1E2D3C4B5A6978);
        add_test("lh_misaligned", OP_LOAD, 1, 1, 0, 17, 0, 0, 1, 0);
        add_test("sd_misaligned", OP_STORE, 1, 3, 0, 36, 64'h55, 0, 1, 0);
        add_test("ld_fault", OP_LOAD, 1, 3, 0, 512, 0, 0, 1, 0);
        add_test("fence", OP_MISC_MEM, 1, 0, 0, 0, 0, 0, 0, 0);
        add_test("unknown_mem", 5'b00001, 1, 3, 0, 8, 0, 0, 1, 0);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < N_TESTS; i++) begin
            @(negedge clk);
            cur_name = names[i];
            n_exc += tests[i].exc;
            exp = '{1'b1, tests[i].exc, tests[i].is_mem, 5'(i % 31 + 1), tests[i].res};
            i_chk.expect_commit(names[i], exp);
            issue = '{1'b1, tests[i].is_mem, tests[i].op, 5'(i % 31 + 1), 5'd1, 5'd2,
                      tests[i].f3, tests[i].f7, tests[i].a, tests[i].b,
                      tests[i].imm, tests[i].imm};
            @(negedge clk);
            issue = '0;
            while (i_chk.n_done <= i) @(posedge clk);
        end

        repeat (2) @(posedge clk);
        i_chk.check_exc_count(n_exc);
        i_chk.check_assertions(i_dut.i_assert.fail_count);
        i_chk.report(fails);
        if (fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/exec_unit_assertions.sv ====
`timescale 1ns/1ps

module exec_unit_assertions
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input issue_t       issue,
    input lsu_req_t     lsu_req,
    input commit_t      commit,
    input unit_result_t alu_res,
    input unit_result_t mem_res
);

    int fail_count = 0;

    // ALU ops and mem ops without an LSU request finish on the next edge
    a_single_cycle: assert property (@(posedge clk) disable iff (rst)
        issue.valid && lsu_req.prev_stalled |=> commit.valid)
        else begin
            $error("no commit one cycle after an issue without LSU request");
            fail_count++;
        end

    a_reset_quiet: assert property (@(posedge clk) rst |=> !commit.valid)
        else begin
            $error("commit valid right after reset");
            fail_count++;
        end

    a_one_unit: assert property (@(posedge clk) disable iff (rst)
        !(alu_res.valid && mem_res.valid))
        else begin
            $error("both units drive a result in one cycle");
            fail_count++;
        end

endmodule

bind exec_unit_top exec_unit_assertions i_assert (
    .clk     (clk),
    .rst     (rst),
    .issue   (issue),
    .lsu_req (lsu_req),
    .commit  (commit),
    .alu_res (alu_res),
    .mem_res (mem_res)
);

// ==== dv/exec_unit_checker.sv ====
`timescale 1ns/1ps

module exec_unit_checker
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  commit_t    commit,
    input  logic [7:0] exc_count
);

    string   exp_name;
    commit_t exp;
    logic    waiting = 1'b0;
    int      n_done  = 0;
    int      n_pass  = 0;
    int      n_fail  = 0;

    task automatic expect_commit(input string name, input commit_t e);
        exp_name = name;
        exp      = e;
        waiting  = 1'b1;
    endtask

    // sample just after the edge, where both commit paths are settled
    always @(posedge clk) begin
        #1;
        if (!rst && commit.valid) begin
            if (!waiting) begin
                $display("commit seen while no test was outstanding");
                n_fail++;
            end else begin
                waiting = 1'b0;
                n_done++;
                if (commit !== exp) begin
                    $write("error %s: expected exc=%0b mem=%0b rd=%0d result=%h",
                           exp_name, exp.exception, exp.from_mem, exp.rd, exp.result);
                    $display(", actual exc=%0b mem=%0b rd=%0d result=%h",
                             commit.exception, commit.from_mem, commit.rd, commit.result);
                    n_fail++;
                end else begin
                    $display("pass %s", exp_name);
                    n_pass++;
                end
            end
        end
    end

    task automatic check_exc_count(input int n);
        if (exc_count !== 8'(n)) begin
            $display("error exc_count: expected %0d, actual %0d", n, exc_count);
            n_fail++;
        end else begin
            $display("pass exc_count");
            n_pass++;
        end
    endtask

    task automatic check_assertions(input int n);
        if (n != 0) begin
            $display("bound assertions failed %0d times during the run", n);
            n_fail++;
        end
    endtask

    task automatic report(output int fails);
        $display("summary: %0d passed, %0d failed", n_pass, n_fail);
        fails = n_fail;
    endtask

endmodule

// ==== design/exec_unit_top.sv ====
`timescale 1ns/1ps

module exec_unit_top
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  issue_t     issue,
    input  lsu_rsp_t   lsu_rsp,
    output lsu_req_t   lsu_req,
    output commit_t    commit,
    output logic [7:0] exc_count
);

    unit_result_t alu_res;
    unit_result_t mem_res;

    // register and immediate arithmetic
    exec_alu i_alu (
        .clk     (clk),
        .rst     (rst),
        .issue   (issue),
        .alu_res (alu_res)
    );

    // loads, stores and FENCE through the outside LSU
    exec_mem i_mem (
        .clk     (clk),
        .rst     (rst),
        .issue   (issue),
        .lsu_rsp (lsu_rsp),
        .lsu_req (lsu_req),
        .mem_res (mem_res)
    );

    // --------------------
    // writeback record
    // --------------------
    exec_commit i_commit (
        .clk       (clk),
        .rst       (rst),
        .alu_res   (alu_res),
        .mem_res   (mem_res),
        .commit    (commit),
        .exc_count (exc_count)
    );

endmodule

// ==== design/exec_commit.sv ====
`timescale 1ns/1ps

module exec_commit
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  unit_result_t alu_res,
    input  unit_result_t mem_res,
    output commit_t      commit,
    output logic [7:0]   exc_count
);

    unit_result_t sel;
    xword_t       wb_result;

    // --------------------
    // result merge
    // --------------------
    // only one unit finishes per cycle, so a plain priority select is enough
    assign sel = mem_res.valid ? mem_res : alu_res;

    // a trapping instruction hands zero to writeback
    assign wb_result = sel.exception ? '0 : sel.result;

    always_comb begin
        commit.valid     = alu_res.valid || mem_res.valid;
        commit.exception = sel.exception;
        commit.from_mem  = mem_res.valid;
        commit.rd        = sel.rd;
        commit.result    = wb_result;
    end

    // --------------------
    // exception counter
    // --------------------
    // saturates at all ones
    always_ff @(posedge clk) begin
        if (rst) begin
            exc_count <= '0;
        end else if (commit.valid && commit.exception && (exc_count != 8'hff)) begin
            exc_count <= exc_count + 8'd1;
        end
    end

endmodule

// ==== design/exec_mem.sv ====
`timescale 1ns/1ps
`include "rv_exec_settings.svh"

module exec_mem
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  issue_t       issue,
    input  lsu_rsp_t     lsu_rsp,
    output lsu_req_t     lsu_req,
    output unit_result_t mem_res
);

    logic                   mem_act;
    logic                   store_bit;
    logic                   is_load_store;
    logic                   is_fence;
    logic                   misaligned;
    imm12_t                 mem_imm;
    addr_t                  eff_addr;
    logic [`ALIGN_BITS-1:0] offset_comb;
    access_size_e           size_comb;
    xword_t                 store_data;
    byte_mask_t             store_mask;

    // state captured on a mem issue, used when the LSU answers
    logic [`ALIGN_BITS-1:0] offset_q;
    access_size_e           size_q;
    logic                   unsigned_q;
    logic                   store_q;
    reg_idx_t               rd_q;

    logic                   single_valid_q;
    logic                   single_exc_q;

    logic [7:0]             ld_byte;
    logic [15:0]            ld_half;
    logic [31:0]            ld_word;
    xword_t                 load_ext;

    // --------------------
    // decode and address
    // --------------------
    assign mem_act       = issue.valid && issue.is_mem;
    assign store_bit     = issue.opcode == OP_STORE;
    assign is_load_store = (issue.opcode == OP_LOAD) || store_bit;
    assign is_fence      = issue.opcode == OP_MISC_MEM;

    assign mem_imm     = store_bit ? issue.s_imm : issue.i_imm;
    assign eff_addr    = issue.rs1_data + {{(`ALEN-12){mem_imm[11]}}, mem_imm};
    assign offset_comb = eff_addr[`ALIGN_BITS-1:0];
    assign size_comb   = access_size_e'(issue.funct3[1:0]);

    // every access must sit on its natural boundary
    always_comb begin
        unique case (size_comb)
            BYTE:  misaligned = 1'b0;
            HALF:  misaligned = offset_comb[0];
            WORD:  misaligned = |offset_comb[1:0];
            DWORD: misaligned = |offset_comb;
        endcase
    end

    // --------------------
    // store formatting
    // --------------------
    // lanes are replicated, the mask picks the ones that are written
    always_comb begin
        unique case (size_comb)
            BYTE: begin
                store_data = {(`XLEN/8){issue.rs2_data[7:0]}};
                store_mask = byte_mask_t'(8'h01) << offset_comb;
            end
            HALF: begin
                store_data = {(`XLEN/16){issue.rs2_data[15:0]}};
                store_mask = byte_mask_t'(8'h03) << offset_comb;
            end
            WORD: begin
                store_data = {(`XLEN/32){issue.rs2_data[31:0]}};
                store_mask = byte_mask_t'(8'h0f) << offset_comb;
            end
            DWORD: begin
                store_data = issue.rs2_data;
                store_mask = '1;
            end
        endcase
    end

    always_comb begin
        lsu_req.prev_stalled = !(mem_act && is_load_store) || misaligned;
        lsu_req.addr         = eff_addr[`ALEN-1 -: `LINE_ADDR_W];
        lsu_req.do_load      = issue.opcode == OP_LOAD;
        lsu_req.do_store     = store_bit;
        lsu_req.store_data   = store_data;
        lsu_req.store_mask   = store_mask;
    end

    // --------------------
    // issue-time registers
    // --------------------
    always_ff @(posedge clk) begin
        if (mem_act) begin
            offset_q   <= offset_comb;
            size_q     <= size_comb;
            unsigned_q <= issue.funct3[2];
            store_q    <= store_bit;
            rd_q       <= issue.rd;
        end
    end

    // misaligned, FENCE and unknown opcodes finish one cycle after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            single_valid_q <= 1'b0;
            single_exc_q   <= 1'b0;
        end else begin
            single_valid_q <= mem_act && (!is_load_store || misaligned);
            single_exc_q   <= mem_act && (is_load_store ? misaligned : !is_fence);
        end
    end

    // --------------------
    // load extraction
    // --------------------
    assign ld_byte = lsu_rsp.load_data[{offset_q, 3'b000} +: 8];
    assign ld_half = lsu_rsp.load_data[{offset_q[2:1], 4'b0000} +: 16];
    assign ld_word = lsu_rsp.load_data[{offset_q[2], 5'b00000} +: 32];

    always_comb begin
        unique case (size_q)
            BYTE:  load_ext = unsigned_q ? xword_t'(ld_byte) :
                              {{(`XLEN-8){ld_byte[7]}}, ld_byte};
            HALF:  load_ext = unsigned_q ? xword_t'(ld_half) :
                              {{(`XLEN-16){ld_half[15]}}, ld_half};
            WORD:  load_ext = unsigned_q ? xword_t'(ld_word) :
                              {{(`XLEN-32){ld_word[31]}}, ld_word};
            DWORD: load_ext = lsu_rsp.load_data;
        endcase
    end

    // LSU answer wins in its cycle, otherwise the registered path
    always_comb begin
        mem_res.rd = rd_q;
        if (!lsu_rsp.stall_next) begin
            mem_res.valid     = 1'b1;
            mem_res.exception = lsu_rsp.access_fault;
            mem_res.result    = store_q ? '0 : load_ext;
        end else begin
            mem_res.valid     = single_valid_q;
            mem_res.exception = single_exc_q;
            mem_res.result    = '0;
        end
    end

endmodule

// ==== design/exec_alu.sv ====
`timescale 1ns/1ps
`include "rv_exec_settings.svh"

module exec_alu
    import rv_isa_pkg::*;
    import rv_exec_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  issue_t       issue,
    output unit_result_t alu_res
);

    logic                     alu_act;
    logic                     known_op;
    logic                     is_sub;
    logic                     lt_signed;
    logic                     lt_unsigned;
    logic [$clog2(`XLEN)-1:0] shamt;
    xword_t                   op_a;
    xword_t                   op_b;
    xword_t                   sra_out;
    xword_t                   alu_out;

    // --------------------
    // operands
    // --------------------
    assign alu_act  = issue.valid && !issue.is_mem;
    assign known_op = (issue.opcode == OP_OP) || (issue.opcode == OP_OP_IMM);

    assign op_a = issue.rs1_data;
    // immediate forms take the sign-extended I-type immediate
    assign op_b = (issue.opcode == OP_OP_IMM) ?
                  {{(`XLEN-12){issue.i_imm[11]}}, issue.i_imm} : issue.rs2_data;

    // no SUBI exists, so only the register form can subtract
    assign is_sub = (issue.opcode == OP_OP) && issue.funct7[5];

    // RV64 uses six shift bits in both forms
    assign shamt = op_b[$clog2(`XLEN)-1:0];

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;
    assign sra_out     = $signed(op_a) >>> shamt;

    // --------------------
    // function select
    // --------------------
    always_comb begin
        unique case (issue.funct3)
            F3_ADD_SUB: alu_out = is_sub ? op_a - op_b : op_a + op_b;
            F3_SLL:     alu_out = op_a << shamt;
            F3_SLT:     alu_out = {{(`XLEN-1){1'b0}}, lt_signed};
            F3_SLTU:    alu_out = {{(`XLEN-1){1'b0}}, lt_unsigned};
            F3_XOR:     alu_out = op_a ^ op_b;
            F3_SRL_SRA: alu_out = issue.funct7[5] ? sra_out : op_a >> shamt;
            F3_OR:      alu_out = op_a | op_b;
            F3_AND:     alu_out = op_a & op_b;
        endcase
    end

    // --------------------
    // result register
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_res.valid <= 1'b0;
        end else begin
            alu_res.valid <= alu_act;
        end

        if (alu_act) begin
            // anything outside OP and OP_IMM is not ours to execute
            alu_res.exception <= !known_op;
            alu_res.rd        <= issue.rd;
            alu_res.result    <= known_op ? alu_out : '0;
        end
    end

endmodule

// ==== design/rv_exec_pkg.sv ====
`include "rv_exec_settings.svh"

package rv_exec_pkg;

    import rv_isa_pkg::*;

    // matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        BYTE  = 2'b00,
        HALF  = 2'b01,
        WORD  = 2'b10,
        DWORD = 2'b11
    } access_size_e;

    typedef logic [`LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [`MASK_W-1:0]      byte_mask_t;

    // prev_stalled high means no request this cycle
    typedef struct packed {
        logic       prev_stalled;
        line_addr_t addr;
        logic       do_load;
        logic       do_store;
        xword_t     store_data;
        byte_mask_t store_mask;
    } lsu_req_t;

    typedef struct packed {
        logic   stall_next;
        logic   access_fault;
        xword_t load_data;
    } lsu_rsp_t;

    typedef struct packed {
        logic     valid;
        logic     exception;
        reg_idx_t rd;
        xword_t   result;
    } unit_result_t;

    typedef struct packed {
        logic     valid;
        logic     exception;
        logic     from_mem;
        reg_idx_t rd;
        xword_t   result;
    } commit_t;

endpackage

// ==== design/rv_isa_pkg.sv ====
`include "rv_exec_settings.svh"

package rv_isa_pkg;

    // major opcode, instruction bits 6:2
    typedef logic [4:0] opcode_t;

    localparam opcode_t OP_LOAD     = 5'b00000;
    localparam opcode_t OP_MISC_MEM = 5'b00011;
    localparam opcode_t OP_OP_IMM   = 5'b00100;
    localparam opcode_t OP_STORE    = 5'b01000;
    localparam opcode_t OP_OP       = 5'b01100;

    typedef logic [2:0] funct3_t;

    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    typedef logic [6:0]        funct7_t;
    typedef logic [4:0]        reg_idx_t;
    typedef logic [11:0]       imm12_t;
    typedef logic [`XLEN-1:0]  xword_t;
    typedef logic [`ALEN-1:0]  addr_t;

    typedef struct packed {
        logic     valid;
        logic     is_mem;
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        funct3_t  funct3;
        funct7_t  funct7;
        xword_t   rs1_data;
        xword_t   rs2_data;
        imm12_t   i_imm;
        imm12_t   s_imm;
    } issue_t;

endpackage

// ==== include/rv_exec_settings.svh ====
`ifndef RV_EXEC_SETTINGS_SVH
`define RV_EXEC_SETTINGS_SVH

// datapath and address widths fixed by RV64
`define XLEN 64
`define ALEN 64

// byte offset inside one aligned 64-bit word
`define ALIGN_BITS 3
`define LINE_ADDR_W (`ALEN - `ALIGN_BITS)
`define MASK_W (`XLEN / 8)

`endif
